// File: fetch_pkg.sv
// Shared definitions for the GDDR6 block fetcher
// Memory layout of one block, bus widths, address types,
// the fetch state encoding and the left/right target encoding
package fetch_pkg;

    // ==================================================================
    // Block layout in GDDR6 lines
    // ==================================================================
    // One exponent burst followed by 32 mantissa bursts
    parameter int LINES_PER_BURST = 16;
    parameter int EXP_LINES       = 16;
    parameter int TOTAL_LINES     = 528;
    parameter int TOTAL_BURSTS    = 33;
    // 32 one-byte exponents packed into each 256-bit line
    parameter int NUM_EXPONENTS   = 512;
    parameter int EXP_PER_LINE    = 32;

    // ==================================================================
    // Widths
    // ==================================================================
    parameter int LINE_WIDTH      = 256;
    parameter int EXP_WIDTH       = 8;
    parameter int AXI_ADDR_WIDTH  = 42;
    parameter int AXI_ID_WIDTH    = 8;
    // 32-byte lines, so the byte address is the line address shifted by 5
    parameter int BYTE_SHIFT      = 5;

    typedef logic [LINE_WIDTH-1:0]     line_data_t;
    typedef logic [EXP_WIDTH-1:0]      exp_t;
    // Line address inside the NAP memory window
    typedef logic [25:0]               ddr_line_t;
    // Tile buffer line, 0 to 527
    typedef logic [9:0]                tile_addr_t;
    typedef logic [8:0]                exp_idx_t;
    typedef logic [AXI_ADDR_WIDTH-1:0] axi_addr_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACTIVE,
        ST_DONE
    } fetch_state_e;

    // Which exponent store receives the unpacked exponents
    typedef enum logic {
        TGT_LEFT,
        TGT_RIGHT
    } target_e;

endpackage

// File: fetch_cmd_if.sv
// Command and progress interface inside the fetcher
// Carries the accepted command from the controller and the
// completion flags back from issuer, line writer and unpacker
`timescale 1ns/1ps

interface fetch_cmd_if;

    // One-cycle strobe when a command is accepted
    logic                  start;
    fetch_pkg::ddr_line_t  base_line;
    fetch_pkg::target_e    target;

    // Progress flags, all cleared by start
    logic                  issue_done;
    logic                  exp_lines_ready;
    logic                  lines_done;
    logic                  unpack_done;

    modport ctrl (output start, output base_line, output target,
                  input issue_done, input lines_done, input unpack_done);

    modport issuer (input start, input base_line, output issue_done);

    modport writer (input start, output exp_lines_ready, output lines_done);

    modport unpacker (input start, input target, input exp_lines_ready,
                      output unpack_done);

endinterface

// File: fetch_ctrl.sv
// Fetch controller
// Idle/active/done FSM, command latch, start strobe and
// the final done pulse once every datapath has finished
`timescale 1ns/1ps

module fetch_ctrl (
    input  logic                  i_clk,
    input  logic                  i_reset_n,
    input  logic                  i_fetch_start,
    input  fetch_pkg::ddr_line_t  i_fetch_line,
    input  fetch_pkg::target_e    i_fetch_target,
    output logic                  o_fetch_done,
    output logic                  o_active,
    fetch_cmd_if.ctrl             cmd
);

    fetch_pkg::fetch_state_e state;
    fetch_pkg::fetch_state_e state_next;
    logic                    accept;
    logic                    all_done;

    // Commands arriving outside idle are dropped
    assign accept    = i_fetch_start && (state == fetch_pkg::ST_IDLE);
    assign cmd.start = accept;

    // Issue, line writes and unpacking all complete
    assign all_done = cmd.issue_done && cmd.lines_done && cmd.unpack_done;

    // ==================================================================
    // State machine
    // ==================================================================
    always_comb begin
        state_next = state;
        case (state)
            fetch_pkg::ST_IDLE: begin
                if (accept) begin
                    state_next = fetch_pkg::ST_ACTIVE;
                end
            end
            fetch_pkg::ST_ACTIVE: begin
                if (all_done) begin
                    state_next = fetch_pkg::ST_DONE;
                end
            end
            fetch_pkg::ST_DONE: begin
                state_next = fetch_pkg::ST_IDLE;
            end
            default: begin
                state_next = fetch_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            state        <= fetch_pkg::ST_IDLE;
            o_fetch_done <= 1'b0;
            cmd.target   <= fetch_pkg::TGT_LEFT;
        end else begin
            state        <= state_next;
            // Done pulse trails ST_DONE by one cycle
            o_fetch_done <= (state == fetch_pkg::ST_DONE);
            if (accept) begin
                cmd.target <= i_fetch_target;
            end
        end
    end

    // Base line held for the whole fetch
    always_ff @(posedge i_clk) begin
        if (accept) begin
            cmd.base_line <= i_fetch_line;
        end
    end

    assign o_active = (state == fetch_pkg::ST_ACTIVE);

endmodule

// File: ar_issuer.sv
// AXI read address issuer
// Steps through the 33 bursts of a block, caps the number of
// bursts in flight and formats the GDDR6 NAP address
`timescale 1ns/1ps

module ar_issuer #(
    parameter int         MAX_OUTSTANDING = 8,
    parameter logic [8:0] PAGE_ID         = 9'd2
) (
    input  logic                                i_clk,
    input  logic                                i_reset_n,
    input  logic                                i_rbeat_last,
    output logic                                o_arvalid,
    input  logic                                i_arready,
    output fetch_pkg::axi_addr_t                o_araddr,
    output logic [7:0]                          o_arlen,
    output logic [fetch_pkg::AXI_ID_WIDTH-1:0]  o_arid,
    fetch_cmd_if.issuer                         cmd
);

    localparam int CNT_W = $clog2(fetch_pkg::TOTAL_BURSTS + 1);
    // Fixed transaction ID for every fetcher burst
    localparam logic [fetch_pkg::AXI_ID_WIDTH-1:0] FETCH_ARID = 8'hFE;

    logic [CNT_W-1:0]     burst_cnt;
    logic [CNT_W-1:0]     burst_next;
    logic [CNT_W-1:0]     outst_cnt;
    logic [CNT_W-1:0]     outst_next;
    logic                 busy;
    logic                 ar_hs;
    fetch_pkg::ddr_line_t line_addr;

    assign ar_hs = o_arvalid && i_arready;

    // Counts as they stand after this cycle
    assign burst_next = burst_cnt + CNT_W'(ar_hs);
    // Up on each AR handshake, down on each beat carrying rlast
    assign outst_next = outst_cnt + CNT_W'(ar_hs) - CNT_W'(i_rbeat_last);

    // ==================================================================
    // Burst and outstanding counters
    // ==================================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            burst_cnt      <= '0;
            outst_cnt      <= '0;
            busy           <= 1'b0;
            o_arvalid      <= 1'b0;
            cmd.issue_done <= 1'b0;
        end else begin
            outst_cnt <= outst_next;
            if (cmd.start) begin
                burst_cnt      <= '0;
                busy           <= 1'b1;
                cmd.issue_done <= 1'b0;
                // First address one cycle after the strobe
                o_arvalid      <= 1'b1;
            end else begin
                burst_cnt <= burst_next;
                // Holds while arready is low, drops at the limit or the end
                o_arvalid <= busy && (burst_next < fetch_pkg::TOTAL_BURSTS)
                             && (outst_next < MAX_OUTSTANDING);
                if (ar_hs && (burst_next == fetch_pkg::TOTAL_BURSTS)) begin
                    busy           <= 1'b0;
                    cmd.issue_done <= 1'b1;
                end
            end
        end
    end

    // ==================================================================
    // NAP address
    // ==================================================================
    // Burst k starts 16 lines past the previous one, kept to 26 bits
    assign line_addr = cmd.base_line
                     + (fetch_pkg::ddr_line_t'(burst_cnt) << $clog2(fetch_pkg::LINES_PER_BURST));

    // Page ID, two reserved upper bits, line, 32-byte offset
    assign o_araddr = {PAGE_ID, 2'b00, line_addr, {fetch_pkg::BYTE_SHIFT{1'b0}}};
    assign o_arlen  = 8'(fetch_pkg::LINES_PER_BURST - 1);
    assign o_arid   = FETCH_ARID;

endmodule

// File: r_line_writer.sv
// Read data receiver
// Accepts R beats while lines remain, numbers them 0 to 527 and
// writes each one to the tile buffer a cycle later
`timescale 1ns/1ps

module r_line_writer (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic                   i_active,
    input  logic                   i_rvalid,
    input  fetch_pkg::line_data_t  i_rdata,
    input  logic                   i_rlast,
    output logic                   o_rready,
    output logic                   o_rbeat_last,
    output logic                   o_buf_wr_en,
    output fetch_pkg::tile_addr_t  o_buf_wr_addr,
    output fetch_pkg::line_data_t  o_buf_wr_data,
    fetch_cmd_if.writer            cmd
);

    fetch_pkg::tile_addr_t line_cnt;
    logic                  beat;

    // No back-pressure beyond the end of the block
    assign o_rready     = i_active && (line_cnt < fetch_pkg::TOTAL_LINES);
    assign beat         = i_rvalid && o_rready;
    assign o_rbeat_last = beat && i_rlast;

    // ==================================================================
    // Line numbering and completion flags
    // ==================================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            line_cnt            <= '0;
            o_buf_wr_en         <= 1'b0;
            cmd.exp_lines_ready <= 1'b0;
            cmd.lines_done      <= 1'b0;
        end else begin
            o_buf_wr_en <= beat;
            if (cmd.start) begin
                line_cnt            <= '0;
                cmd.exp_lines_ready <= 1'b0;
                cmd.lines_done      <= 1'b0;
            end else begin
                if (beat) begin
                    line_cnt <= line_cnt + 1'b1;
                end
                // Packed exponents are lines 0 to 15
                if (o_buf_wr_en && (o_buf_wr_addr == fetch_pkg::EXP_LINES - 1)) begin
                    cmd.exp_lines_ready <= 1'b1;
                end
                if (o_buf_wr_en && (o_buf_wr_addr == fetch_pkg::TOTAL_LINES - 1)) begin
                    cmd.lines_done <= 1'b1;
                end
            end
        end
    end

    // Write address and line captured with the beat
    always_ff @(posedge i_clk) begin
        if (beat) begin
            o_buf_wr_addr <= line_cnt;
            o_buf_wr_data <= i_rdata;
        end
    end

endmodule

// File: exp_unpacker.sv
// Exponent unpacker
// Reads the 16 packed lines back from the tile buffer and writes
// one exponent byte per cycle into the left or right store
`timescale 1ns/1ps

module exp_unpacker (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic                   i_active,
    output fetch_pkg::tile_addr_t  o_exp_rd_addr,
    input  fetch_pkg::line_data_t  i_exp_rd_data,
    output logic                   o_exp_left_wr_en,
    output logic                   o_exp_right_wr_en,
    output fetch_pkg::exp_idx_t    o_exp_wr_addr,
    output fetch_pkg::exp_t        o_exp_wr_data,
    fetch_cmd_if.unpacker          cmd
);

    localparam int BYTE_SEL_W = $clog2(fetch_pkg::EXP_PER_LINE);

    fetch_pkg::exp_idx_t rd_idx;
    logic                rd_busy;
    logic                wr_valid;
    logic                launch;

    // Once per fetch, after the exponent lines land
    assign launch = i_active && cmd.exp_lines_ready && !rd_busy && !wr_valid
                    && !cmd.unpack_done;

    // ==================================================================
    // Read stage, one index per cycle
    // ==================================================================
    always_ff @(posedge i_clk) begin
        if (!i_reset_n) begin
            rd_busy         <= 1'b0;
            rd_idx          <= '0;
            wr_valid        <= 1'b0;
            cmd.unpack_done <= 1'b0;
        end else begin
            wr_valid <= rd_busy;
            if (cmd.start) begin
                rd_busy         <= 1'b0;
                rd_idx          <= '0;
                cmd.unpack_done <= 1'b0;
            end else begin
                if (launch) begin
                    rd_busy <= 1'b1;
                end else if (rd_busy) begin
                    rd_idx <= rd_idx + 1'b1;
                    if (rd_idx == fetch_pkg::NUM_EXPONENTS - 1) begin
                        rd_busy <= 1'b0;
                    end
                end
                if (wr_valid && (o_exp_wr_addr == fetch_pkg::NUM_EXPONENTS - 1)) begin
                    cmd.unpack_done <= 1'b1;
                end
            end
        end
    end

    // Index i lives in packed line i/32
    assign o_exp_rd_addr = fetch_pkg::tile_addr_t'(rd_idx[8:BYTE_SEL_W]);

    // ==================================================================
    // Write stage, lined up with the one-cycle read latency
    // ==================================================================
    always_ff @(posedge i_clk) begin
        o_exp_wr_addr <= rd_idx;
    end

    // Byte i mod 32 of the returned line
    assign o_exp_wr_data = i_exp_rd_data[o_exp_wr_addr[BYTE_SEL_W-1:0] * fetch_pkg::EXP_WIDTH
                                         +: fetch_pkg::EXP_WIDTH];

    assign o_exp_left_wr_en  = wr_valid && (cmd.target == fetch_pkg::TGT_LEFT);
    assign o_exp_right_wr_en = wr_valid && (cmd.target == fetch_pkg::TGT_RIGHT);

endmodule

// File: gddr_fetcher.sv
// GDDR6 block fetcher top level
// Command port, AXI4 read channels, tile buffer write and read
// ports, exponent store writes; controller plus three datapaths
`timescale 1ns/1ps

module gddr_fetcher #(
    parameter int         MAX_OUTSTANDING = 8,
    parameter logic [8:0] PAGE_ID         = 9'd2
) (
    input  logic                                i_clk,
    input  logic                                i_reset_n,

    // Fetch command
    input  logic                                i_fetch_start,
    input  fetch_pkg::ddr_line_t                i_fetch_line,
    input  fetch_pkg::target_e                  i_fetch_target,
    output logic                                o_fetch_done,

    // AXI4 read address
    output logic                                o_arvalid,
    input  logic                                i_arready,
    output fetch_pkg::axi_addr_t                o_araddr,
    output logic [7:0]                          o_arlen,
    output logic [fetch_pkg::AXI_ID_WIDTH-1:0]  o_arid,

    // AXI4 read data
    input  logic                                i_rvalid,
    input  fetch_pkg::line_data_t               i_rdata,
    input  logic                                i_rlast,
    output logic                                o_rready,

    // Tile buffer write
    output logic                                o_buf_wr_en,
    output fetch_pkg::tile_addr_t               o_buf_wr_addr,
    output fetch_pkg::line_data_t               o_buf_wr_data,

    // Packed exponent read, one-cycle latency
    output fetch_pkg::tile_addr_t               o_exp_rd_addr,
    input  fetch_pkg::line_data_t               i_exp_rd_data,

    // Exponent stores
    output logic                                o_exp_left_wr_en,
    output logic                                o_exp_right_wr_en,
    output fetch_pkg::exp_idx_t                 o_exp_wr_addr,
    output fetch_pkg::exp_t                     o_exp_wr_data
);

    logic active;
    // Accepted R beat that closed a burst
    logic rbeat_last;

    fetch_cmd_if cmd_if ();

    fetch_ctrl u_ctrl (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_fetch_start  (i_fetch_start),
        .i_fetch_line   (i_fetch_line),
        .i_fetch_target (i_fetch_target),
        .o_fetch_done   (o_fetch_done),
        .o_active       (active),
        .cmd            (cmd_if.ctrl)
    );

    ar_issuer #(
        .MAX_OUTSTANDING (MAX_OUTSTANDING),
        .PAGE_ID         (PAGE_ID)
    ) u_issuer (
        .i_clk        (i_clk),
        .i_reset_n    (i_reset_n),
        .i_rbeat_last (rbeat_last),
        .o_arvalid    (o_arvalid),
        .i_arready    (i_arready),
        .o_araddr     (o_araddr),
        .o_arlen      (o_arlen),
        .o_arid       (o_arid),
        .cmd          (cmd_if.issuer)
    );

    r_line_writer u_writer (
        .i_clk         (i_clk),
        .i_reset_n     (i_reset_n),
        .i_active      (active),
        .i_rvalid      (i_rvalid),
        .i_rdata       (i_rdata),
        .i_rlast       (i_rlast),
        .o_rready      (o_rready),
        .o_rbeat_last  (rbeat_last),
        .o_buf_wr_en   (o_buf_wr_en),
        .o_buf_wr_addr (o_buf_wr_addr),
        .o_buf_wr_data (o_buf_wr_data),
        .cmd           (cmd_if.writer)
    );

    exp_unpacker u_unpacker (
        .i_clk             (i_clk),
        .i_reset_n         (i_reset_n),
        .i_active          (active),
        .o_exp_rd_addr     (o_exp_rd_addr),
        .i_exp_rd_data     (i_exp_rd_data),
        .o_exp_left_wr_en  (o_exp_left_wr_en),
        .o_exp_right_wr_en (o_exp_right_wr_en),
        .o_exp_wr_addr     (o_exp_wr_addr),
        .o_exp_wr_data     (o_exp_wr_data),
        .cmd               (cmd_if.unpacker)
    );

endmodule

// File: tb_clock_gen.sv
// Testbench clock and reset generator
// Free-running clock and a synchronous active-low reset
`timescale 1ns/1ps

module tb_clock_gen #(
    parameter real PERIOD_NS    = 8.0,
    parameter int  RESET_CYCLES = 4
) (
    output logic o_clk,
    output logic o_reset_n
);

    initial begin
        o_clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2.0) o_clk = ~o_clk;
        end
    end

    // Released on a falling edge, clear of the sampling edge
    initial begin
        o_reset_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge o_clk);
        @(negedge o_clk);
        o_reset_n = 1'b1;
    end

endmodule

// File: tb_gddr_fetcher.sv
// Testbench for the GDDR6 block fetcher
// AXI read slave model, tile buffer model, stimulus file reader,
// typed compare tasks and a cycle-limit timeout
`timescale 1ns/1ps

module tb_gddr_fetcher;

    localparam int         MAX_OUT = 8;
    localparam logic [8:0] PAGE_ID = 9'd2;
    localparam int         CYCLES_PER_TEST = 4000;

    logic clk;
    logic reset_n;

    logic                                i_fetch_start;
    fetch_pkg::ddr_line_t                i_fetch_line;
    fetch_pkg::target_e                  i_fetch_target;
    logic                                o_fetch_done;
    logic                                o_arvalid;
    logic                                i_arready;
    fetch_pkg::axi_addr_t                o_araddr;
    logic [7:0]                          o_arlen;
    logic [fetch_pkg::AXI_ID_WIDTH-1:0]  o_arid;
    logic                                i_rvalid;
    fetch_pkg::line_data_t               i_rdata;
    logic                                i_rlast;
    logic                                o_rready;
    logic                                o_buf_wr_en;
    fetch_pkg::tile_addr_t               o_buf_wr_addr;
    fetch_pkg::line_data_t               o_buf_wr_data;
    fetch_pkg::tile_addr_t               o_exp_rd_addr;
    fetch_pkg::line_data_t               i_exp_rd_data;
    logic                                o_exp_left_wr_en;
    logic                                o_exp_right_wr_en;
    fetch_pkg::exp_idx_t                 o_exp_wr_addr;
    fetch_pkg::exp_t                     o_exp_wr_data;

    // Expected lines in return order, and what the buffer received
    fetch_pkg::line_data_t exp_lines [0:fetch_pkg::TOTAL_LINES-1];
    fetch_pkg::line_data_t tile_mem  [0:fetch_pkg::TOTAL_LINES-1];

    // Stimulus columns
    logic [31:0] q_base [$];
    int          q_tgt [$];
    int          q_ar_gap [$];
    int          q_r_gap [$];
    int          q_seed [$];

    fetch_pkg::ddr_line_t  cur_base;
    fetch_pkg::target_e    cur_target;
    fetch_pkg::target_e    got_tgt;
    fetch_pkg::tile_addr_t rd_addr_q;
    // ID seen on the first burst of the run
    logic [fetch_pkg::AXI_ID_WIDTH-1:0] fixed_arid;
    bit                                 arid_seen;
    int ar_gap, r_gap, ar_wait, r_wait;
    int ar_count, line_sent, buf_writes, exp_count, done_count;
    int outstanding, peak_outstanding;
    int errors, checks, cycles, cycle_limit;
    bit ar_hs_now, r_hs_now;

    tb_clock_gen #(.PERIOD_NS(8.0), .RESET_CYCLES(4)) u_clk_gen (
        .o_clk     (clk),
        .o_reset_n (reset_n)
    );

    gddr_fetcher #(.MAX_OUTSTANDING(MAX_OUT), .PAGE_ID(PAGE_ID)) u_dut (
        .i_clk (clk), .i_reset_n (reset_n),
        .i_fetch_start (i_fetch_start), .i_fetch_line (i_fetch_line),
        .i_fetch_target (i_fetch_target), .o_fetch_done (o_fetch_done),
        .o_arvalid (o_arvalid), .i_arready (i_arready), .o_araddr (o_araddr),
        .o_arlen (o_arlen), .o_arid (o_arid),
        .i_rvalid (i_rvalid), .i_rdata (i_rdata), .i_rlast (i_rlast), .o_rready (o_rready),
        .o_buf_wr_en (o_buf_wr_en), .o_buf_wr_addr (o_buf_wr_addr),
        .o_buf_wr_data (o_buf_wr_data),
        .o_exp_rd_addr (o_exp_rd_addr), .i_exp_rd_data (i_exp_rd_data),
        .o_exp_left_wr_en (o_exp_left_wr_en), .o_exp_right_wr_en (o_exp_right_wr_en),
        .o_exp_wr_addr (o_exp_wr_addr), .o_exp_wr_data (o_exp_wr_data)
    );

    // ======================================================================
    // Compare tasks
    // ======================================================================
    task automatic check_addr(input fetch_pkg::axi_addr_t got, input fetch_pkg::axi_addr_t exp,
                              input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_id(input logic [fetch_pkg::AXI_ID_WIDTH-1:0] got,
                            input logic [fetch_pkg::AXI_ID_WIDTH-1:0] exp, input string what);
        checks++;
        if ((got !== exp) || $isunknown(got)) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_line(input fetch_pkg::line_data_t got,
                              input fetch_pkg::line_data_t exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_exp(input fetch_pkg::exp_t got, input fetch_pkg::exp_t exp,
                             input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_target(input fetch_pkg::target_e got, input fetch_pkg::target_e exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED at %0t: %s got %s expected %s", $time, what, got.name(), exp.name());
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        checks++;
        if (got != exp) begin
            errors++;
            $display("FAILED at %0t: %s got %0d expected %0d", $time, what, got, exp);
        end
    endtask

    // Burst k holds the page ID, two zero bits, base plus 16k in 26 bits and a 32-byte offset
    function automatic fetch_pkg::axi_addr_t expected_araddr(input fetch_pkg::ddr_line_t base,
                                                            input int k);
        fetch_pkg::ddr_line_t line;
        line = base + fetch_pkg::ddr_line_t'(k * fetch_pkg::LINES_PER_BURST);
        return {PAGE_ID, 2'b00, line, 5'b00000};
    endfunction

    // ======================================================================
    // Monitor sampling pre-update values on the rising edge
    // ======================================================================
    always @(posedge clk) begin
        ar_hs_now = o_arvalid && i_arready;
        r_hs_now  = i_rvalid && o_rready;
        rd_addr_q = o_exp_rd_addr;
        if (ar_hs_now) begin
            if (ar_count >= fetch_pkg::TOTAL_BURSTS) begin
                errors++;
                $display("Extra AR burst %0d accepted at %0t", ar_count, $time);
            end
            check_addr(o_araddr, expected_araddr(cur_base, ar_count), "AR address");
            check_count(int'(o_arlen), fetch_pkg::LINES_PER_BURST - 1, "AR burst length");
            // Every burst of every fetch carries the same ID
            if (!arid_seen) begin
                fixed_arid = o_arid;
                arid_seen  = 1'b1;
            end
            check_id(o_arid, fixed_arid, "AR ID");
            ar_count++;
            outstanding++;
        end
        if (r_hs_now && i_rlast) begin
            outstanding--;
        end
        // Bursts in flight must respect the issuer limit
        if (outstanding > MAX_OUT) begin
            errors++;
            $display("FAILED at %0t: %0d bursts outstanding, limit %0d", $time, outstanding, MAX_OUT);
        end
        if (outstanding > peak_outstanding) begin
            peak_outstanding = outstanding;
        end
        // Tile buffer writes land in return order
        if (o_buf_wr_en) begin
            check_count(int'(o_buf_wr_addr), buf_writes, "Buffer write address");
            if (o_buf_wr_addr < fetch_pkg::TOTAL_LINES) begin
                check_line(o_buf_wr_data, exp_lines[o_buf_wr_addr], "Buffer line");
                tile_mem[o_buf_wr_addr] = o_buf_wr_data;
            end
            buf_writes++;
        end
        if (o_exp_left_wr_en && o_exp_right_wr_en) begin
            errors++;
            $display("Both exponent store enables high at %0t", $time);
        end else if (o_exp_left_wr_en || o_exp_right_wr_en) begin
            got_tgt = o_exp_right_wr_en ? fetch_pkg::TGT_RIGHT : fetch_pkg::TGT_LEFT;
            check_target(got_tgt, cur_target, "Exponent store");
            check_count(int'(o_exp_wr_addr), exp_count, "Exponent address");
            if (exp_count < fetch_pkg::NUM_EXPONENTS) begin
                check_exp(o_exp_wr_data,
                          exp_lines[exp_count / fetch_pkg::EXP_PER_LINE]
                                   [8 * (exp_count % fetch_pkg::EXP_PER_LINE) +: 8],
                          "Exponent byte");
            end
            exp_count++;
        end
        // Done only after every line and exponent is written
        if (o_fetch_done) begin
            done_count++;
            check_count(buf_writes, fetch_pkg::TOTAL_LINES, "Buffer writes at done");
            check_count(exp_count, fetch_pkg::NUM_EXPONENTS, "Exponent writes at done");
        end
    end

    // ======================================================================
    // AXI slave and tile buffer read port driven on the falling edge
    // ======================================================================
    always @(negedge clk) begin
        // One-cycle read latency
        i_exp_rd_data = (rd_addr_q < fetch_pkg::TOTAL_LINES) ? tile_mem[rd_addr_q] : '0;
        if (ar_hs_now) begin
            i_arready = 1'b0;
            ar_wait   = 0;
        end
        if (o_arvalid && !i_arready) begin
            if (ar_wait >= ar_gap) begin
                i_arready = 1'b1;
            end else begin
                ar_wait++;
            end
        end
        if (r_hs_now) begin
            i_rvalid = 1'b0;
            i_rlast  = 1'b0;
            line_sent++;
            r_wait   = 0;
        end
        // Beats only for bursts already accepted
        if (!i_rvalid && (line_sent < ar_count * fetch_pkg::LINES_PER_BURST)
                && (line_sent < fetch_pkg::TOTAL_LINES)) begin
            if (r_wait >= r_gap) begin
                i_rvalid = 1'b1;
                i_rdata  = exp_lines[line_sent];
                i_rlast  = (line_sent % fetch_pkg::LINES_PER_BURST)
                           == (fetch_pkg::LINES_PER_BURST - 1);
            end else begin
                r_wait++;
            end
        end
    end

    // Cycle limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > cycle_limit) begin
            $display("Timeout after %0d cycles, fetch did not complete", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic read_stim();
        int          fd;
        int          n;
        string       line_str;
        logic [31:0] base;
        int          tgt, agap, rgap, sd;
        fd = $fopen("fetch_stim.txt", "r");
        if (fd == 0) begin
            errors++;
            $display("Could not open stimulus file fetch_stim.txt");
        end else begin
            while (!$feof(fd)) begin
                line_str = "";
                n = $fgets(line_str, fd);
                if ((line_str.len() > 1) && (line_str.substr(0, 0) != "#")) begin
                    n = $sscanf(line_str, "%h %h %h %h %h", base, tgt, agap, rgap, sd);
                    if (n == 5) begin
                        q_base.push_back(base);
                        q_tgt.push_back(tgt);
                        q_ar_gap.push_back(agap);
                        q_r_gap.push_back(rgap);
                        q_seed.push_back(sd);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int t);
        integer seed;
        seed = 32'h3436 + q_seed[t];
        for (int n = 0; n < fetch_pkg::TOTAL_LINES; n++) begin
            for (int w = 0; w < fetch_pkg::LINE_WIDTH / 32; w++) begin
                exp_lines[n][32 * w +: 32] = $random(seed);
            end
        end
        cur_base   = fetch_pkg::ddr_line_t'(q_base[t]);
        cur_target = fetch_pkg::target_e'(q_tgt[t][0]);
        ar_gap     = q_ar_gap[t];
        r_gap      = q_r_gap[t];
        // Slave sees no pending beats at any point of this reset
        ar_count   = 0;
        line_sent  = 0;
        buf_writes = 0;
        exp_count  = 0;
        done_count = 0;
        peak_outstanding = 0;
        i_fetch_start  = 1'b1;
        i_fetch_line   = cur_base;
        i_fetch_target = cur_target;
        @(negedge clk);
        i_fetch_start = 1'b0;
        // Command sent while busy is dropped
        repeat (20) @(negedge clk);
        i_fetch_start  = 1'b1;
        i_fetch_line   = cur_base + 26'h1234;
        i_fetch_target = (cur_target == fetch_pkg::TGT_LEFT) ? fetch_pkg::TGT_RIGHT
                                                             : fetch_pkg::TGT_LEFT;
        @(negedge clk);
        i_fetch_start = 1'b0;
        while (done_count == 0) begin
            @(negedge clk);
        end
        repeat (8) @(negedge clk);
        check_count(done_count, 1, "Done pulses");
        check_count(ar_count, fetch_pkg::TOTAL_BURSTS, "AR handshakes");
        check_count(buf_writes, fetch_pkg::TOTAL_LINES, "Buffer writes");
        check_count(exp_count, fetch_pkg::NUM_EXPONENTS, "Exponent writes");
        $display("Test %0d base %h %s peak outstanding %0d",
                 t, cur_base, cur_target.name(), peak_outstanding);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        i_fetch_start  = 1'b0;
        i_fetch_line   = '0;
        i_fetch_target = fetch_pkg::TGT_LEFT;
        i_arready      = 1'b0;
        i_rvalid       = 1'b0;
        i_rdata        = '0;
        i_rlast        = 1'b0;
        i_exp_rd_data  = '0;
        cycle_limit    = CYCLES_PER_TEST;
        read_stim();
        if (q_base.size() == 0) begin
            errors++;
            $display("No tests found in the stimulus file");
        end
        cycle_limit = CYCLES_PER_TEST * (q_base.size() + 1);
        @(posedge reset_n);
        @(negedge clk);
        check_count(int'({o_arvalid, o_rready, o_buf_wr_en, o_exp_left_wr_en,
                          o_exp_right_wr_en, o_fetch_done}), 0, "Outputs after reset");
        for (int t = 0; t < q_base.size(); t++) begin
            run_test(t);
        end
        $display("Summary: %0d tests, %0d checks, %0d errors", q_base.size(), checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: fetch_stim.txt
# Columns in hex: base_line target ar_gap r_gap seed
# target 0 selects the left exponent store, 1 the right
0000000 0 0 0 00
0001000 1 0 3 11
00ABCD0 0 2 0 22
3FFFFF0 1 1 2 33
0123456 1 3 4 44
0000200 0 0 1 55

// File: project.f
fetch_pkg.sv
fetch_cmd_if.sv
fetch_ctrl.sv
ar_issuer.sv
r_line_writer.sv
exp_unpacker.sv
gddr_fetcher.sv
tb_clock_gen.sv
tb_gddr_fetcher.sv
